//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       = tb_cpu_core
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf $(OBJ_DIR)

//--- files.f
+incdir+tb
src/cpu_pkg.sv
src/instr_port.sv
src/reg_file.sv
src/decode.sv
src/id_ex.sv
src/execute.sv
src/cpu_core.sv
tb/tb_cpu_core.sv

//--- src/cpu_core.sv
`timescale 1ns/10ps

module cpu_core import cpu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     instr_req,
    input  word_t    instr,
    output logic     instr_ack,
    output logic     wb_en,
    output reg_idx_t wb_reg,
    output word_t    wb_data,
    output logic     halted
);

    logic     buf_valid;
    word_t    buf_instr;
    logic     take;
    logic     stall_n;
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    word_t    rs_data;
    word_t    rt_data;

    // decode outputs
    word_t    opa;
    word_t    opb;
    alu_op_e  alu_op;
    logic     inv_a;
    logic     inv_b;
    logic     cin;
    logic     sign;
    set_sel_e set_sel;
    logic     wr_en;
    reg_idx_t wr_reg;
    logic     halt;

    // held in id_ex
    word_t    ex_opa;
    word_t    ex_opb;
    alu_op_e  ex_alu_op;
    logic     ex_inv_a;
    logic     ex_inv_b;
    logic     ex_cin;
    logic     ex_sign;
    set_sel_e ex_set_sel;
    logic     ex_wr_en;
    reg_idx_t ex_wr_reg;
    logic     ex_halt;

    instr_port u_port (
        .clk       (clk),
        .arst_n    (arst_n),
        .instr_req (instr_req),
        .instr     (instr),
        .instr_ack (instr_ack),
        .halted    (halted),
        .take      (take),
        .buf_valid (buf_valid),
        .buf_instr (buf_instr)
    );

    decode u_dec (
        .buf_valid (buf_valid),
        .buf_instr (buf_instr),
        .take      (take),
        .rs_idx    (rs_idx),
        .rt_idx    (rt_idx),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .ex_wr_en  (ex_wr_en),
        .ex_wr_reg (ex_wr_reg),
        .stall_n   (stall_n),
        .opa       (opa),
        .opb       (opb),
        .alu_op    (alu_op),
        .inv_a     (inv_a),
        .inv_b     (inv_b),
        .cin       (cin),
        .sign      (sign),
        .set_sel   (set_sel),
        .wr_en     (wr_en),
        .wr_reg    (wr_reg),
        .halt      (halt)
    );

    reg_file u_rf (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb_en   (wb_en),
        .wb_reg  (wb_reg),
        .wb_data (wb_data)
    );

    id_ex u_idex (
        .clk        (clk),
        .arst_n     (arst_n),
        .stall_n    (stall_n),
        .valid_in   (take),
        .opa        (opa),
        .opb        (opb),
        .alu_op     (alu_op),
        .inv_a      (inv_a),
        .inv_b      (inv_b),
        .cin        (cin),
        .sign       (sign),
        .set_sel    (set_sel),
        .wr_en      (wr_en),
        .wr_reg     (wr_reg),
        .halt       (halt),
        .ex_opa     (ex_opa),
        .ex_opb     (ex_opb),
        .ex_alu_op  (ex_alu_op),
        .ex_inv_a   (ex_inv_a),
        .ex_inv_b   (ex_inv_b),
        .ex_cin     (ex_cin),
        .ex_sign    (ex_sign),
        .ex_set_sel (ex_set_sel),
        .ex_wr_en   (ex_wr_en),
        .ex_wr_reg  (ex_wr_reg),
        .ex_halt    (ex_halt)
    );

    execute u_ex (
        .clk        (clk),
        .arst_n     (arst_n),
        .ex_opa     (ex_opa),
        .ex_opb     (ex_opb),
        .ex_alu_op  (ex_alu_op),
        .ex_inv_a   (ex_inv_a),
        .ex_inv_b   (ex_inv_b),
        .ex_cin     (ex_cin),
        .ex_sign    (ex_sign),
        .ex_set_sel (ex_set_sel),
        .ex_wr_en   (ex_wr_en),
        .ex_wr_reg  (ex_wr_reg),
        .ex_halt    (ex_halt),
        .wb_en      (wb_en),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data),
        .halted     (halted)
    );

endmodule

//--- src/cpu_pkg.sv
package cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_idx_t;

    // instr[15:12], R-format rd/rs/rt at 11:9, 8:6, 5:3; I-format imm6 at 5:0
    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_ADD   = 4'd1,   // rd = rs + rt
        OP_SUB   = 4'd2,   // rd = rs - rt
        OP_AND   = 4'd3,
        OP_OR    = 4'd4,
        OP_XOR   = 4'd5,
        OP_SLL   = 4'd6,   // rd = rs << rt[3:0]
        OP_SRL   = 4'd7,   // logical
        OP_ADDI  = 4'd8,   // rd = rs + sext(imm)
        OP_RSUBI = 4'd9,   // rd = sext(imm) - rs
        OP_SEQ   = 4'd10,
        OP_SLT   = 4'd11,  // signed
        OP_SLE   = 4'd12,  // signed
        OP_SCO   = 4'd13,  // carry out of rs + rt
        OP_HALT  = 4'd14
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_AND = 3'd1,
        ALU_OR  = 3'd2,
        ALU_XOR = 3'd3,
        ALU_SLL = 3'd4,
        ALU_SRL = 3'd5
    } alu_op_e;

    // three bits since five conditions do not fit in two
    typedef enum logic [2:0] {
        SET_NONE = 3'd0,  // write the alu result
        SET_EQ   = 3'd1,
        SET_LT   = 3'd2,
        SET_LE   = 3'd3,
        SET_CO   = 3'd4
    } set_sel_e;

endpackage

//--- src/decode.sv
`timescale 1ns/10ps

module decode import cpu_pkg::*; (
    input  logic     buf_valid,
    input  word_t    buf_instr,
    output logic     take,
    output reg_idx_t rs_idx,
    output reg_idx_t rt_idx,
    input  word_t    rs_data,
    input  word_t    rt_data,
    input  logic     ex_wr_en,
    input  reg_idx_t ex_wr_reg,
    output logic     stall_n,
    output word_t    opa,
    output word_t    opb,
    output alu_op_e  alu_op,
    output logic     inv_a,
    output logic     inv_b,
    output logic     cin,
    output logic     sign,
    output set_sel_e set_sel,
    output logic     wr_en,
    output reg_idx_t wr_reg,
    output logic     halt
);

    opcode_e opcode;
    word_t   sext_imm;
    logic    use_rs;
    logic    use_rt;
    logic    hazard;

    assign opcode   = opcode_e'(buf_instr[15:12]);
    assign wr_reg   = buf_instr[11:9];
    assign rs_idx   = buf_instr[8:6];
    assign rt_idx   = buf_instr[5:3];
    assign sext_imm = {{10{buf_instr[5]}}, buf_instr[5:0]};

    assign opa = rs_data;
    assign opb = use_rt ? rt_data : sext_imm;

    always_comb begin
        alu_op  = ALU_ADD;
        inv_a   = 1'b0;
        inv_b   = 1'b0;
        cin     = 1'b0;
        sign    = 1'b0;
        set_sel = SET_NONE;
        wr_en   = 1'b1;
        halt    = 1'b0;
        use_rs  = 1'b1;
        use_rt  = 1'b1;
        case (opcode)
            OP_ADD:   ;
            OP_SUB: begin
                inv_b = 1'b1;
                cin   = 1'b1;
            end
            OP_AND:   alu_op = ALU_AND;
            OP_OR:    alu_op = ALU_OR;
            OP_XOR:   alu_op = ALU_XOR;
            OP_SLL:   alu_op = ALU_SLL;
            OP_SRL:   alu_op = ALU_SRL;
            OP_ADDI:  use_rt = 1'b0;
            OP_RSUBI: begin
                use_rt = 1'b0;
                inv_a  = 1'b1;   // imm + ~rs + 1
                cin    = 1'b1;
            end
            OP_SEQ, OP_SLT, OP_SLE: begin
                inv_b   = 1'b1;  // compare on rs - rt
                cin     = 1'b1;
                sign    = (opcode != OP_SEQ);
                set_sel = (opcode == OP_SEQ) ? SET_EQ :
                          (opcode == OP_SLT) ? SET_LT : SET_LE;
            end
            OP_SCO:   set_sel = SET_CO;
            OP_HALT: begin
                halt   = 1'b1;
                wr_en  = 1'b0;
                use_rs = 1'b0;
                use_rt = 1'b0;
            end
            default: begin       // NOP and the unused code
                wr_en  = 1'b0;
                use_rs = 1'b0;
                use_rt = 1'b0;
            end
        endcase
    end

    // writer still in id_ex has no result yet, wb stage is covered by the rf bypass
    assign hazard = buf_valid && ex_wr_en &&
                    ((use_rs && ex_wr_reg == rs_idx) || (use_rt && ex_wr_reg == rt_idx));

    assign stall_n = !hazard;
    assign take    = buf_valid && stall_n;

endmodule

//--- src/execute.sv
`timescale 1ns/10ps

module execute import cpu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  word_t    ex_opa,
    input  word_t    ex_opb,
    input  alu_op_e  ex_alu_op,
    input  logic     ex_inv_a,
    input  logic     ex_inv_b,
    input  logic     ex_cin,
    input  logic     ex_sign,
    input  set_sel_e ex_set_sel,
    input  logic     ex_wr_en,
    input  reg_idx_t ex_wr_reg,
    input  logic     ex_halt,
    output logic     wb_en,
    output reg_idx_t wb_reg,
    output word_t    wb_data,
    output logic     halted
);

    word_t a;
    word_t b;
    word_t sum;
    logic  cout;
    logic  ovf;
    logic  zero;
    logic  lt;
    word_t alu_res;
    word_t result;

    assign a = ex_inv_a ? ~ex_opa : ex_opa;
    assign b = ex_inv_b ? ~ex_opb : ex_opb;

    assign {cout, sum} = {1'b0, a} + {1'b0, b} + {16'd0, ex_cin};

    assign ovf  = (a[15] == b[15]) && (sum[15] != a[15]);
    assign zero = (sum == '0);
    // unsigned: a - b borrows when there is no carry out
    assign lt   = ex_sign ? (sum[15] ^ ovf) : !cout;

    always_comb begin
        case (ex_alu_op)
            ALU_ADD: alu_res = sum;
            ALU_AND: alu_res = a & b;
            ALU_OR:  alu_res = a | b;
            ALU_XOR: alu_res = a ^ b;
            ALU_SLL: alu_res = a << b[3:0];
            ALU_SRL: alu_res = a >> b[3:0];
            default: alu_res = sum;
        endcase
    end

    always_comb begin
        case (ex_set_sel)
            SET_EQ:  result = {15'd0, zero};
            SET_LT:  result = {15'd0, lt};
            SET_LE:  result = {15'd0, lt | zero};
            SET_CO:  result = {15'd0, cout};
            default: result = alu_res;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_en  <= 1'b0;
            halted <= 1'b0;
        end else begin
            wb_en <= ex_wr_en;
            if (ex_halt) halted <= 1'b1;   // sticky
        end
    end

    always_ff @(posedge clk) begin
        wb_reg  <= ex_wr_reg;
        wb_data <= result;
    end

    // the port stops feeding decode once halted, so nothing may retire after it
    a_no_wb_after_halt: assert property (@(posedge clk) disable iff (!arst_n)
        halted |-> !wb_en);

endmodule

//--- src/id_ex.sv
`timescale 1ns/10ps

module id_ex import cpu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     stall_n,
    input  logic     valid_in,
    input  word_t    opa,
    input  word_t    opb,
    input  alu_op_e  alu_op,
    input  logic     inv_a,
    input  logic     inv_b,
    input  logic     cin,
    input  logic     sign,
    input  set_sel_e set_sel,
    input  logic     wr_en,
    input  reg_idx_t wr_reg,
    input  logic     halt,
    output word_t    ex_opa,
    output word_t    ex_opb,
    output alu_op_e  ex_alu_op,
    output logic     ex_inv_a,
    output logic     ex_inv_b,
    output logic     ex_cin,
    output logic     ex_sign,
    output set_sel_e ex_set_sel,
    output logic     ex_wr_en,
    output reg_idx_t ex_wr_reg,
    output logic     ex_halt
);

    // operands and controls freeze while decode stalls
    always_ff @(posedge clk) begin
        if (stall_n) begin
            ex_opa     <= opa;
            ex_opb     <= opb;
            ex_alu_op  <= alu_op;
            ex_inv_a   <= inv_a;
            ex_inv_b   <= inv_b;
            ex_cin     <= cin;
            ex_sign    <= sign;
            ex_set_sel <= set_sel;
            ex_wr_reg  <= wr_reg;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_wr_en <= 1'b0;
            ex_halt  <= 1'b0;
        end else begin
            ex_wr_en <= valid_in & wr_en;   // no take means a bubble
            ex_halt  <= valid_in & halt;
        end
    end

    // the bubble drops the hazard, so a stall lasts one cycle
    a_stall_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        !stall_n |=> (stall_n && !ex_wr_en));

    // decode must never hand over a slot it is stalling on
    a_no_take_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
        !stall_n |-> !valid_in);

endmodule

//--- src/instr_port.sv
`timescale 1ns/10ps

module instr_port import cpu_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  instr_req,
    input  word_t instr,
    output logic  instr_ack,
    input  logic  halted,
    input  logic  take,
    output logic  buf_valid,
    output word_t buf_instr
);

    typedef enum logic [1:0] {
        IDLE,
        HELD,       // buffer full, ack still low
        WAIT_DROP   // ack high until req falls
    } state_e;

    state_e state;
    state_e state_nxt;
    word_t  buf_q;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:      if (instr_req && !halted) state_nxt = HELD;
            HELD:      if (take) state_nxt = WAIT_DROP;
            WAIT_DROP: if (!instr_req) state_nxt = IDLE;
            default:   state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && instr_req) buf_q <= instr;
    end

    assign instr_ack = (state == WAIT_DROP);
    assign buf_valid = (state == HELD) && !halted; // nothing leaves once halted
    assign buf_instr = buf_q;

    // source must hold req until it sees ack
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        (!instr_ack && !instr_req) |=> !instr_ack);

endmodule

//--- src/reg_file.sv
`timescale 1ns/10ps

module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    output word_t    rs_data,
    output word_t    rt_data,
    input  logic     wb_en,
    input  reg_idx_t wb_reg,
    input  word_t    wb_data
);

    word_t regs [8];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_reg] <= wb_data;
        end
    end

    // writeback in flight wins over the stored value
    assign rs_data = (wb_en && wb_reg == rs_idx) ? wb_data : regs[rs_idx];
    assign rt_data = (wb_en && wb_reg == rt_idx) ? wb_data : regs[rt_idx];

endmodule

//--- tb/ref_model.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// instruction-level model, included inside the testbench module
word_t    model_rf [8];
reg_idx_t exp_reg_q [$];     // expected writebacks, program order
word_t    exp_data_q [$];
int       writes_expected;

function automatic void clear_model();
    for (int i = 0; i < 8; i++) begin
        model_rf[i] = '0;
    end
    exp_reg_q.delete();
    exp_data_q.delete();
    writes_expected = 0;
endfunction

// runs one instruction on the model and queues its result if it writes
task automatic apply_instr(input word_t ins);
    opcode_e     op;
    reg_idx_t    rd;
    word_t       rs_v;
    word_t       rt_v;
    word_t       imm_v;
    word_t       res;
    logic [16:0] wide;
    bit          writes;
    op     = opcode_e'(ins[15:12]);
    rd     = ins[11:9];
    rs_v   = model_rf[ins[8:6]];
    rt_v   = model_rf[ins[5:3]];
    imm_v  = {{10{ins[5]}}, ins[5:0]};
    res    = '0;
    wide   = '0;
    writes = 1'b1;
    case (op)
        OP_ADD:   res = rs_v + rt_v;
        OP_SUB:   res = rs_v - rt_v;
        OP_AND:   res = rs_v & rt_v;
        OP_OR:    res = rs_v | rt_v;
        OP_XOR:   res = rs_v ^ rt_v;
        OP_SLL:   res = rs_v << rt_v[3:0];
        OP_SRL:   res = rs_v >> rt_v[3:0];
        OP_ADDI:  res = rs_v + imm_v;
        OP_RSUBI: res = imm_v - rs_v;
        OP_SEQ:   res = (rs_v == rt_v) ? 16'd1 : 16'd0;
        OP_SLT:   res = ($signed(rs_v) < $signed(rt_v)) ? 16'd1 : 16'd0;
        OP_SLE:   res = ($signed(rs_v) <= $signed(rt_v)) ? 16'd1 : 16'd0;
        OP_SCO: begin
            wide = {1'b0, rs_v} + {1'b0, rt_v};
            res  = {15'd0, wide[16]};     // unsigned carry out
        end
        default:  writes = 1'b0;          // NOP, HALT
    endcase
    if (writes) begin
        model_rf[rd] = res;
        exp_reg_q.push_back(rd);
        exp_data_q.push_back(res);
        writes_expected++;
    end
endtask

`endif

//--- tb/tb_cpu_core.sv
`timescale 1ns/10ps

module tb_cpu_core import cpu_pkg::*; ();

    localparam int N_SEED_INSTR   = 8;
    localparam int N_RANDOM       = 240;
    localparam int N_INSTR        = N_SEED_INSTR + N_RANDOM + 1;  // plus the HALT
    localparam int TIMEOUT_CYCLES = 10 * N_INSTR + 100;

    logic     clk;
    logic     arst_n;
    logic     instr_req;
    word_t    instr;
    logic     instr_ack;
    logic     wb_en;
    reg_idx_t wb_reg;
    word_t    wb_data;
    logic     halted;

    int       check_errors;
    int       other_errors;
    int       wb_count;
    int       cycle_cnt;
    bit       halted_seen;
    reg_idx_t last_rd;
    word_t    ins;

    `include "ref_model.svh"

    cpu_core u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .instr_req (instr_req),
        .instr     (instr),
        .instr_ack (instr_ack),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            check_errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (exp !== act) begin
            check_errors++;
            $display("CHECK FAILED %s: expected r%0d, actual r%0d", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            check_errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    function automatic word_t make_r(input opcode_e op, input reg_idx_t rd,
                                     input reg_idx_t rs, input reg_idx_t rt);
        return {op, rd, rs, rt, 3'b000};
    endfunction

    function automatic word_t make_i(input opcode_e op, input reg_idx_t rd,
                                     input reg_idx_t rs, input logic [5:0] imm);
        return {op, rd, rs, imm};
    endfunction

    // sources lean on the previous destination to exercise the hazard path
    function automatic word_t random_instr(input reg_idx_t prev_rd);
        opcode_e    op;
        reg_idx_t   rd;
        reg_idx_t   rs;
        reg_idx_t   rt;
        logic [5:0] imm;
        if ($urandom_range(0, 19) == 0) begin
            op = OP_NOP;
        end else begin
            op = opcode_e'(4'($urandom_range(1, 13)));
        end
        rd  = reg_idx_t'($urandom_range(0, 7));
        rs  = ($urandom_range(0, 99) < 60) ? prev_rd : reg_idx_t'($urandom_range(0, 7));
        rt  = ($urandom_range(0, 99) < 50) ? prev_rd : reg_idx_t'($urandom_range(0, 7));
        imm = 6'($urandom);
        if (op == OP_ADDI || op == OP_RSUBI) begin
            return make_i(op, rd, rs, imm);
        end
        return make_r(op, rd, rs, rt);
    endfunction

    // four-phase: raise req, wait ack, drop req, wait ack low
    task automatic send_instr(input word_t word);
        instr     = word;
        instr_req = 1'b1;
        @(negedge clk);
        while (!instr_ack) @(negedge clk);
        instr_req = 1'b0;
        @(negedge clk);
        while (instr_ack) @(negedge clk);
    endtask

    task automatic issue_instr(input word_t word);
        apply_instr(word);
        send_instr(word);
    endtask

    // retire monitor, outputs are settled at the falling edge
    always @(negedge clk) begin
        if (arst_n) begin
            if (wb_en) begin
                wb_count++;
                if (halted) begin
                    other_errors++;
                    $display("writeback to r%0d seen after halt", wb_reg);
                end
                if (exp_reg_q.size() == 0) begin
                    other_errors++;
                    $display("unexpected writeback to r%0d, none pending", wb_reg);
                end else begin
                    check_reg($sformatf("wb reg #%0d", wb_count), exp_reg_q.pop_front(), wb_reg);
                    check_word($sformatf("wb data #%0d", wb_count), exp_data_q.pop_front(),
                               wb_data);
                end
            end
            if (halted && !halted_seen) begin
                halted_seen = 1'b1;
                if (exp_reg_q.size() != 0) begin
                    other_errors++;
                    $display("halted rose with %0d writebacks still pending", exp_reg_q.size());
                end
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Something failed");
        $finish;
    end

    initial begin
        void'($urandom(30));
        arst_n       = 1'b0;
        instr_req    = 1'b0;
        instr        = '0;
        check_errors = 0;
        other_errors = 0;
        wb_count     = 0;
        halted_seen  = 1'b0;
        last_rd      = '0;
        clear_model();

        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_bit("ack after reset", 1'b0, instr_ack);
        check_bit("wb_en after reset", 1'b0, wb_en);
        check_bit("halted after reset", 1'b0, halted);

        // give every register a nonzero start
        for (int i = 0; i < N_SEED_INSTR; i++) begin
            issue_instr(make_i(OP_ADDI, reg_idx_t'(i), reg_idx_t'(i), 6'($urandom)));
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            ins = random_instr(last_rd);
            issue_instr(ins);
            last_rd = ins[11:9];
        end
        issue_instr(make_r(OP_HALT, 3'd0, 3'd0, 3'd0));
        while (!halted) @(negedge clk);

        // a pending request after halt gets no ack
        instr     = make_r(OP_ADD, 3'd1, 3'd1, 3'd1);
        instr_req = 1'b1;
        repeat (20) begin
            @(negedge clk);
            check_bit("ack after halt", 1'b0, instr_ack);
        end
        instr_req = 1'b0;
        repeat (3) @(negedge clk);

        if (exp_reg_q.size() != 0) begin
            other_errors++;
            $display("%0d expected writebacks never arrived", exp_reg_q.size());
        end
        if (wb_count != writes_expected) begin
            other_errors++;
            $display("writeback count %0d does not match %0d writing instructions",
                     wb_count, writes_expected);
        end
        $display("summary: %0d check errors, %0d other errors, %0d of %0d writebacks",
                 check_errors, other_errors, wb_count, writes_expected);
        if (check_errors == 0 && other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
